//--- hdl/rename_pkg.sv
// fixed geometry of 32 architectural and 64 physical registers; other sizes need new types here
package rename_pkg;

    // register file geometry
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // free list and history hold every register beyond the architectural set
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FREE_IDX_W = $clog2(FREE_DEPTH);

    // architectural register index, x0..x31
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // physical register number, p0 is permanently x0
    typedef logic [$clog2(PHYS_REGS)-1:0] preg_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // queue pointer with one wrap bit
    typedef logic [FREE_IDX_W:0] hist_ptr_t;

    // major opcodes seen by the decoder, bits [6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

endpackage

//--- hdl/rename_decode.sv
// one instruction per strobe, no back-pressure; unknown opcodes rename with no sources and no rd
`timescale 1ns/1ps

module rename_decode import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      inst_valid,
    input  inst_t     inst,
    input  logic      flush,
    input  logic      empty,
    output arch_reg_t dec_rs1,
    output arch_reg_t dec_rs2,
    output arch_reg_t dec_rd,
    output logic      dec_writes_rd,
    output logic      alloc,
    output logic      out_valid,
    output logic      overflow
);

    opcode_e opc;
    logic    use_rs1;
    logic    use_rs2;
    logic    use_rd;
    logic    writes_rd;
    logic    vld_q;
    logic    wr_q;

    assign opc = opcode_e'(inst[6:0]);

    // which fields the instruction format actually carries
    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (opc)
            OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
            end
            OP_IMM, LOAD, JALR: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            STORE, BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            LUI, AUIPC, JAL: begin
                use_rd = 1'b1;
            end
            default: begin
                use_rd = 1'b0;
            end
        endcase
    end

    // rd = x0 never needs a fresh register
    assign writes_rd = use_rd && (inst[11:7] != '0);

    // strobe and write flag, flush drops whatever arrives this cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            vld_q <= 1'b0;
            wr_q  <= 1'b0;
        end else begin
            vld_q <= inst_valid;
            wr_q  <= inst_valid && writes_rd;
        end
    end

    // register indices, unused ones forced to x0
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec_rs1 <= use_rs1 ? arch_reg_t'(inst[19:15]) : '0;
            dec_rs2 <= use_rs2 ? arch_reg_t'(inst[24:20]) : '0;
            dec_rd  <= writes_rd ? arch_reg_t'(inst[11:7]) : '0;
        end
    end

    assign dec_writes_rd = wr_q;

    // rd writer with an empty free list is dropped and reported
    assign out_valid = vld_q && (!wr_q || !empty);
    assign overflow  = vld_q && wr_q && empty;
    assign alloc     = vld_q && wr_q && !empty;

endmodule

//--- hdl/map_table.sv
// x0 always reads p0 ready; flush restores every entry from the architectural map, all ready
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  arch_reg_t dec_rs1,
    input  arch_reg_t dec_rs2,
    input  arch_reg_t dec_rd,
    input  logic      alloc,
    input  preg_t     alloc_preg,
    input  logic      cdb_valid,
    input  preg_t     cdb_preg,
    input  logic      ret_valid,
    input  arch_reg_t ret_rd,
    input  preg_t     ret_new_preg,
    input  logic      flush,
    input  arch_reg_t arch_query_idx,
    output preg_t     prs1,
    output preg_t     prs2,
    output preg_t     old_preg,
    output preg_t     arch_query_preg,
    output logic      prs1_ready,
    output logic      prs2_ready
);

    // speculative map with ready bits
    preg_t                spec_map [ARCH_REGS];
    logic [ARCH_REGS-1:0] spec_rdy;

    // committed state, no ready bit since retired values are complete
    preg_t                arch_map [ARCH_REGS];

    // source lookup, {ready, preg}
    // a broadcast this cycle already counts as ready
    function automatic logic [$bits(preg_t):0] read_src(arch_reg_t idx);
        preg_t p;
        logic  rdy;
        p   = spec_map[idx];
        rdy = spec_rdy[idx] || (cdb_valid && (cdb_preg == p));
        if (idx == '0) begin
            p   = '0;
            rdy = 1'b1;
        end
        return {rdy, p};
    endfunction

    // sources read the mapping from before this cycle's write
    always_comb begin
        {prs1_ready, prs1} = read_src(dec_rs1);
        {prs2_ready, prs2} = read_src(dec_rs2);
    end

    // previous mapping of rd, reported with the rename
    assign old_preg = (dec_rd == '0) ? preg_t'(0) : spec_map[dec_rd];

    // committed mapping for external query
    assign arch_query_preg = (arch_query_idx == '0) ? preg_t'(0) : arch_map[arch_query_idx];

    // speculative map update
    // later statements win: cdb, then new dest, then flush restore
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= preg_t'(i);
            end
            spec_rdy <= '1;
        end else begin
            // every entry mapped to the broadcast register becomes ready
            if (cdb_valid) begin
                for (int i = 0; i < ARCH_REGS; i++) begin
                    if (spec_map[i] == cdb_preg) begin
                        spec_rdy[i] <= 1'b1;
                    end
                end
            end

            // fresh destination waits for its own broadcast
            if (alloc) begin
                spec_map[dec_rd] <= alloc_preg;
                spec_rdy[dec_rd] <= 1'b0;
            end

            // restore, forwarding a retire from the same cycle
            if (flush) begin
                for (int i = 0; i < ARCH_REGS; i++) begin
                    if (ret_valid && (ret_rd == arch_reg_t'(i))) begin
                        spec_map[i] <= ret_new_preg;
                    end else begin
                        spec_map[i] <= arch_map[i];
                    end
                end
                spec_rdy <= '1;
            end
        end
    end

    // architectural map, written only at retire
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                arch_map[i] <= preg_t'(i);
            end
        end else if (ret_valid) begin
            arch_map[ret_rd] <= ret_new_preg;
        end
    end

endmodule

//--- hdl/free_list.sv
// alloc must only be raised while empty is low; holds FREE_DEPTH registers, starting at ARCH_REGS
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  alloc,
    input  logic  ret_valid,
    input  preg_t ret_old_preg,
    input  logic  flush,
    output preg_t alloc_preg,
    output logic  empty
);

    preg_t     mem [FREE_DEPTH];

    // head: next to hand out
    // commit_head: oldest register not yet retired
    // tail: where freed registers go back
    hist_ptr_t head;
    hist_ptr_t commit_head;
    hist_ptr_t tail;
    hist_ptr_t commit_next;

    // tail always sits one full lap ahead of commit_head
    assign commit_next = ret_valid ? commit_head + hist_ptr_t'(1) : commit_head;

    assign alloc_preg = mem[head[FREE_IDX_W-1:0]];
    assign empty      = (head == tail);

    always_ff @(posedge clk) begin
        if (reset) begin
            head        <= '0;
            commit_head <= '0;
            tail        <= hist_ptr_t'(FREE_DEPTH);
        end else begin
            commit_head <= commit_next;
            if (ret_valid) begin
                tail <= tail + hist_ptr_t'(1);
            end
            // flush rewinds past everything speculative, retire included
            if (flush) begin
                head <= commit_next;
            end else if (alloc) begin
                head <= head + hist_ptr_t'(1);
            end
        end
    end

    // contents start as ARCH_REGS..PHYS_REGS-1 in order
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                mem[i] <= preg_t'(ARCH_REGS + i);
            end
        end else if (ret_valid) begin
            // slot under tail held the register just committed
            mem[tail[FREE_IDX_W-1:0]] <= ret_old_preg;
        end
    end

endmodule

//--- hdl/rename_history.sv
// never overflows since pushes are bounded by free-list capacity; retire with nothing pending is ignored
`timescale 1ns/1ps

module rename_history import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      alloc,
    input  arch_reg_t dec_rd,
    input  preg_t     alloc_preg,
    input  preg_t     old_preg,
    input  logic      retire_valid,
    input  logic      flush,
    output logic      ret_valid,
    output arch_reg_t ret_rd,
    output preg_t     ret_new_preg,
    output preg_t     ret_old_preg
);

    // one entry per allocated rename, oldest at head
    arch_reg_t rd_mem  [FREE_DEPTH];
    preg_t     new_mem [FREE_DEPTH];
    preg_t     old_mem [FREE_DEPTH];

    hist_ptr_t head;
    hist_ptr_t tail;
    logic      hist_empty;

    assign hist_empty = (head == tail);

    // retire only counts when something is pending
    assign ret_valid = retire_valid && !hist_empty;

    // oldest entry is always presented
    assign ret_rd       = rd_mem[head[FREE_IDX_W-1:0]];
    assign ret_new_preg = new_mem[head[FREE_IDX_W-1:0]];
    assign ret_old_preg = old_mem[head[FREE_IDX_W-1:0]];

    // pointers
    // flush discards all, retire this cycle already went to the map
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (ret_valid) begin
                head <= head + hist_ptr_t'(1);
            end
            if (alloc) begin
                tail <= tail + hist_ptr_t'(1);
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_mem[tail[FREE_IDX_W-1:0]]  <= dec_rd;
            new_mem[tail[FREE_IDX_W-1:0]] <= alloc_preg;
            old_mem[tail[FREE_IDX_W-1:0]] <= old_preg;
        end
    end

endmodule

//--- hdl/rename_unit.sv
// single rename per cycle, fixed latency 1, overflow reported instead of stalling; environment orders retires
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      inst_valid,
    input  inst_t     inst,
    input  logic      cdb_valid,
    input  preg_t     cdb_preg,
    input  logic      retire_valid,
    input  logic      flush,
    input  arch_reg_t arch_query_idx,
    output logic      out_valid,
    output preg_t     out_prs1,
    output logic      out_prs1_ready,
    output preg_t     out_prs2,
    output logic      out_prs2_ready,
    output logic      out_writes_rd,
    output preg_t     out_prd,
    output preg_t     out_old_prd,
    output logic      overflow,
    output logic      rename_full,
    output preg_t     arch_query_preg
);

    // decode to map
    arch_reg_t dec_rs1;
    arch_reg_t dec_rs2;
    arch_reg_t dec_rd;
    logic      alloc;

    // free list
    preg_t     alloc_preg;
    logic      empty;

    // map to history
    preg_t     old_preg;

    // retiring entry
    logic      ret_valid;
    arch_reg_t ret_rd;
    preg_t     ret_new_preg;
    preg_t     ret_old_preg;

    rename_decode rename_decode_inst (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .flush         (flush),
        .empty         (empty),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_writes_rd (out_writes_rd),
        .alloc         (alloc),
        .out_valid     (out_valid),
        .overflow      (overflow)
    );

    map_table map_table_inst (
        .clk             (clk),
        .reset           (reset),
        .dec_rs1         (dec_rs1),
        .dec_rs2         (dec_rs2),
        .dec_rd          (dec_rd),
        .alloc           (alloc),
        .alloc_preg      (alloc_preg),
        .cdb_valid       (cdb_valid),
        .cdb_preg        (cdb_preg),
        .ret_valid       (ret_valid),
        .ret_rd          (ret_rd),
        .ret_new_preg    (ret_new_preg),
        .flush           (flush),
        .arch_query_idx  (arch_query_idx),
        .prs1            (out_prs1),
        .prs2            (out_prs2),
        .old_preg        (old_preg),
        .arch_query_preg (arch_query_preg),
        .prs1_ready      (out_prs1_ready),
        .prs2_ready      (out_prs2_ready)
    );

    free_list free_list_inst (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .ret_valid    (ret_valid),
        .ret_old_preg (ret_old_preg),
        .flush        (flush),
        .alloc_preg   (alloc_preg),
        .empty        (empty)
    );

    rename_history rename_history_inst (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .dec_rd       (dec_rd),
        .alloc_preg   (alloc_preg),
        .old_preg     (old_preg),
        .retire_valid (retire_valid),
        .flush        (flush),
        .ret_valid    (ret_valid),
        .ret_rd       (ret_rd),
        .ret_new_preg (ret_new_preg),
        .ret_old_preg (ret_old_preg)
    );

    // new and old destination ride along with the rename
    assign out_prd     = alloc_preg;
    assign out_old_prd = old_preg;

    // no free register left for another rd writer
    assign rename_full = empty;

endmodule

//--- verification/rename_unit_asserts.sv
// protocol checks sampled at the rising edge; all but the post-reset check are off during reset
`timescale 1ns/1ps

module rename_unit_asserts import rename_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  inst_valid,
    input logic  out_valid,
    input logic  overflow,
    input logic  out_writes_rd,
    input preg_t out_prd
);

    // one outcome per decoded instruction
    strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(out_valid && overflow))
        else $error("out_valid and overflow high in the same cycle");

    // fixed latency of one, nothing appears without a strobe
    strobe_has_source: assert property (@(posedge clk) disable iff (reset)
        (out_valid || overflow) |-> $past(inst_valid))
        else $error("rename result without inst_valid one cycle earlier");

    // p0 belongs to x0 and is never handed out
    prd_not_zero: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_writes_rd) |-> (out_prd != '0))
        else $error("destination mapped to physical register 0");

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clk)
        $past(reset) |-> (!out_valid && !overflow))
        else $error("rename strobe high right after reset");

endmodule

bind rename_unit rename_unit_asserts rename_unit_asserts_inst (
    .clk           (clk),
    .reset         (reset),
    .inst_valid    (inst_valid),
    .out_valid     (out_valid),
    .overflow      (overflow),
    .out_writes_rd (out_writes_rd),
    .out_prd       (out_prd)
);

//--- verification/rename_unit_tb.sv
// random rename traffic from a fixed seed; checks every cycle against a queue-based model
`timescale 1ns/1ps

module rename_unit_tb import rename_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 4000;
    // retire rate alternates so the history fills, overflows and drains
    localparam int PHASE_LEN    = 150;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD;

    logic      clk;
    logic      reset;
    logic      inst_valid;
    inst_t     inst;
    logic      cdb_valid;
    preg_t     cdb_preg;
    logic      retire_valid;
    logic      flush;
    arch_reg_t arch_query_idx;
    logic      out_valid;
    preg_t     out_prs1;
    logic      out_prs1_ready;
    preg_t     out_prs2;
    logic      out_prs2_ready;
    logic      out_writes_rd;
    preg_t     out_prd;
    preg_t     out_old_prd;
    logic      overflow;
    logic      rename_full;
    preg_t     arch_query_preg;

    // model state
    preg_t                m_spec [ARCH_REGS];
    logic [ARCH_REGS-1:0] m_rdy;
    preg_t                m_arch [ARCH_REGS];
    preg_t                m_free [$];
    // history entry {rd, new preg, old preg}
    logic [16:0]          m_hist [$];

    // instruction captured last cycle
    logic      p_valid;
    logic      p_wr;
    arch_reg_t p_rs1;
    arch_reg_t p_rs2;
    arch_reg_t p_rd;

    logic [31:0] rng_state;
    int          n_checks;
    int          n_errors;
    int          cyc;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rename_unit rename_unit_inst (
        .clk             (clk),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .cdb_valid       (cdb_valid),
        .cdb_preg        (cdb_preg),
        .retire_valid    (retire_valid),
        .flush           (flush),
        .arch_query_idx  (arch_query_idx),
        .out_valid       (out_valid),
        .out_prs1        (out_prs1),
        .out_prs1_ready  (out_prs1_ready),
        .out_prs2        (out_prs2),
        .out_prs2_ready  (out_prs2_ready),
        .out_writes_rd   (out_writes_rd),
        .out_prd         (out_prd),
        .out_old_prd     (out_old_prd),
        .overflow        (overflow),
        .rename_full     (rename_full),
        .arch_query_preg (arch_query_preg)
    );

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // the nine major opcodes in RV32I encoding
    function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:    return 7'b0110011;
            4'd1:    return 7'b0010011;
            4'd2:    return 7'b0000011;
            4'd3:    return 7'b0100011;
            4'd4:    return 7'b1100011;
            4'd5:    return 7'b0110111;
            4'd6:    return 7'b0010111;
            4'd7:    return 7'b1101111;
            default: return 7'b1100111;
        endcase
    endfunction

    // {rs1, rs2, rd} present in the format
    function automatic logic [2:0] fields_used(input logic [6:0] opc);
        case (opc)
            7'b0110011:                         return 3'b111;
            7'b0010011, 7'b0000011, 7'b1100111: return 3'b101;
            7'b0100011, 7'b1100011:             return 3'b110;
            7'b0110111, 7'b0010111, 7'b1101111: return 3'b001;
            default:                            return 3'b000;
        endcase
    endfunction

    task automatic check_val(input string name, input int exp, input int act);
        n_checks++;
        assert (exp == act) else begin
            n_errors++;
            $display("** Error [%s] cycle %0d: expected %0d, actual %0d", name, cyc, exp, act);
        end
    endtask

    // x0 reads p0 ready, a same-cycle broadcast counts as ready
    task automatic check_source(input string name, input arch_reg_t idx,
                                input preg_t act_p, input logic act_r);
        preg_t exp_p;
        logic  exp_r;
        if (idx == 5'd0) begin
            exp_p = '0;
            exp_r = 1'b1;
        end else begin
            exp_p = m_spec[idx];
            exp_r = m_rdy[idx] || (cdb_valid && (cdb_preg == exp_p));
        end
        check_val(name, int'(exp_p), int'(act_p));
        check_val({name, "_ready"}, int'(exp_r), int'(act_r));
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic        fill;
        r    = next_rand();
        fill = ((cyc / PHASE_LEN) % 2) == 0;
        inst_valid = (r[2:0] != 3'd0);
        inst       = next_rand();
        // narrow the register fields now and then for more dependencies
        if (r[3]) begin
            inst = inst & ~32'h018C0C00;
        end
        inst[6:0]      = pick_opcode(4'(r[31:24] % 8'd9));
        cdb_valid      = r[4];
        cdb_preg       = r[21:16];
        retire_valid   = fill ? (r[7:5] == 3'd0) : (r[7:5] != 3'd0);
        flush          = (r[15:8] == 8'd0);
        arch_query_idx = arch_reg_t'(cyc);
    endtask

    task automatic check_outputs();
        logic exp_valid;
        logic exp_ovf;
        exp_valid = p_valid && (!p_wr || (m_free.size() != 0));
        exp_ovf   = p_valid && p_wr && (m_free.size() == 0);
        check_val("out_valid", int'(exp_valid), int'(out_valid));
        check_val("overflow", int'(exp_ovf), int'(overflow));
        check_val("rename_full", int'(m_free.size() == 0), int'(rename_full));
        check_val("arch_query", int'(m_arch[arch_query_idx]), int'(arch_query_preg));
        if (exp_valid) begin
            check_source("prs1", p_rs1, out_prs1, out_prs1_ready);
            check_source("prs2", p_rs2, out_prs2, out_prs2_ready);
            check_val("writes_rd", int'(p_wr), int'(out_writes_rd));
            if (p_wr) begin
                check_val("prd", int'(m_free[0]), int'(out_prd));
                check_val("old_prd", int'(m_spec[p_rd]), int'(out_old_prd));
            end
        end
    endtask

    // state change at the coming edge
    task automatic update_model();
        logic        do_ret;
        logic        do_alloc;
        logic [16:0] e;
        preg_t       old;
        logic [2:0]  used;
        do_ret   = retire_valid && (m_hist.size() != 0);
        do_alloc = p_valid && p_wr && (m_free.size() != 0);
        if (cdb_valid) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                if (m_spec[i] == cdb_preg) m_rdy[i] = 1'b1;
            end
        end
        if (do_alloc) begin
            old = m_spec[p_rd];
            m_hist.push_back({p_rd, m_free[0], old});
            m_spec[p_rd] = m_free.pop_front();
            m_rdy[p_rd]  = 1'b0;
        end
        // oldest rename commits, its old register goes back at the end
        if (do_ret) begin
            e = m_hist.pop_front();
            m_arch[e[16:12]] = e[11:6];
            m_free.push_back(e[5:0]);
        end
        if (flush) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                m_spec[i] = m_arch[i];
            end
            m_rdy = '1;
            // speculative registers return to the front in allocation order
            for (int i = m_hist.size() - 1; i >= 0; i--) begin
                m_free.push_front(m_hist[i][11:6]);
            end
            m_hist.delete();
            p_valid = 1'b0;
        end else begin
            used    = fields_used(inst[6:0]);
            p_valid = inst_valid;
            p_wr    = inst_valid && used[0] && (inst[11:7] != 5'd0);
            p_rs1   = used[2] ? inst[19:15] : 5'd0;
            p_rs2   = used[1] ? inst[24:20] : 5'd0;
            p_rd    = p_wr ? inst[11:7] : 5'd0;
        end
    endtask

    initial begin
        rng_state      = 32'h1907;
        n_checks       = 0;
        n_errors       = 0;
        cyc            = 0;
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst           = '0;
        cdb_valid      = 1'b0;
        cdb_preg       = '0;
        retire_valid   = 1'b0;
        flush          = 1'b0;
        arch_query_idx = '0;
        // identity maps, all ready, free list 32..63
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_spec[i] = preg_t'(i);
            m_arch[i] = preg_t'(i);
            m_free.push_back(preg_t'(ARCH_REGS + i));
        end
        m_rdy   = '1;
        p_valid = 1'b0;
        p_wr    = 1'b0;
        p_rs1   = '0;
        p_rs2   = '0;
        p_rd    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_inputs();
            // outputs settled well before the falling edge
            #40;
            check_outputs();
            update_model();
            @(posedge clk);
            #1;
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // stimulus length plus margin
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired at %0t, stimulus loop did not finish", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- rename_unit.f
hdl/rename_pkg.sv
hdl/rename_decode.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/rename_history.sv
hdl/rename_unit.sv
verification/rename_unit_asserts.sv
verification/rename_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rename unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rename_unit_tb \
    -f rename_unit.f \
    -o rename_unit_sim

./obj_dir/rename_unit_sim 2>&1 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "rename_unit: PASS"
else
    echo "rename_unit: FAIL"
    exit 1
fi
